// ==== core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data and address width
`define XLEN 32
// rv32e register file, sixteen entries
`define REG_AW 4
`define REG_NUM 16
// csr address width
`define CSR_AW 12

// first fetch address and trap vector out of reset
`define RESET_PC 32'h0000_0000
`define MTVEC_RESET 32'h0000_0080

// machine csr addresses
`define CSR_MSTATUS 12'h300
`define CSR_MTVEC 12'h305
`define CSR_MEPC 12'h341
`define CSR_MCAUSE 12'h342

// mcause codes
`define CAUSE_ILLEGAL 32'd2
`define CAUSE_ECALL 32'd11

`endif

// ==== core_pkg.sv ====
package core_pkg;

    // alu function
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS_B
    } alu_op_e;

    // alu operand a source
    typedef enum logic [1:0] {OPA_RS1, OPA_PC, OPA_ZERO} opa_sel_e;

    // alu operand b source
    typedef enum logic {OPB_RS2, OPB_IMM} opb_sel_e;

    // next pc source
    typedef enum logic [2:0] {
        PC_PLUS4, PC_BRANCH, PC_JAL, PC_JALR, PC_TRAP, PC_MRET
    } pc_sel_e;

    // rd data source
    typedef enum logic [1:0] {WB_ALU, WB_PC4, WB_CSR} wb_sel_e;

    // csr instruction kind
    typedef enum logic [1:0] {CSR_NONE, CSR_RW, CSR_RS} csr_op_e;

    // branch compare
    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_op_e;

    // fetch fsm
    typedef enum logic [1:0] {
        FETCH_REQ, FETCH_WAIT, FETCH_HOLD, FETCH_STALL
    } fetch_state_e;

endpackage

// ==== core_stim.txt ====
// program words by word address, then from @80 the expected retirement trace
// trace columns: pc next_pc rd_wen rd_addr rd_data trap, a row of all ones ends it
// 00: alu group, x1 = -5 and x2 = 3
FFB00093 00300113 002081B3 40110233
0020F2B3 0020E333 0020C3B3 0020A433
0020B4B3 4020D533 0020D5B3 00209633
// 30: srai, slti, addi to x0, add reading x0
4010D693 FFC0A713 00710013 002007B3
// 40: branches, taken ones skip a nop
00210463 00000013 00208463 00209463
00000013 00211463 0020C463 00000013
00114463 00115463 00000013 0020D463
00116463 00000013 0020E463 0020F463
00000013 00117463 00C002EF 00000013
// 90: jalr to an odd address
00000013 0A100313 000303E7 00000013
// a0: csr writes, ecall, illegal word, jump to self
10000493 30549573 305025F3 08800613
300626F3 30012773 300027F3 00000073
00000000 0000006F
// 100: trap handler, mepc advanced by 4 then mret
@40
342020F3 341021F3 00418193 34119073
30200073
@80
00000000 00000004 1 1 FFFFFFFB 0
00000004 00000008 1 2 00000003 0
00000008 0000000C 1 3 FFFFFFFE 0
0000000C 00000010 1 4 00000008 0
00000010 00000014 1 5 00000003 0
00000014 00000018 1 6 FFFFFFFB 0
00000018 0000001C 1 7 FFFFFFF8 0
0000001C 00000020 1 8 00000001 0
00000020 00000024 1 9 00000000 0
00000024 00000028 1 A FFFFFFFF 0
00000028 0000002C 1 B 1FFFFFFF 0
0000002C 00000030 1 C FFFFFFD8 0
00000030 00000034 1 D FFFFFFFD 0
00000034 00000038 1 E 00000001 0
00000038 0000003C 0 0 00000000 0
0000003C 00000040 1 F 00000003 0
00000040 00000048 0 0 00000000 0
00000048 0000004C 0 0 00000000 0
0000004C 00000054 0 0 00000000 0
00000054 00000058 0 0 00000000 0
00000058 00000060 0 0 00000000 0
00000060 00000064 0 0 00000000 0
00000064 0000006C 0 0 00000000 0
0000006C 00000070 0 0 00000000 0
00000070 00000078 0 0 00000000 0
00000078 0000007C 0 0 00000000 0
0000007C 00000084 0 0 00000000 0
00000084 00000088 0 0 00000000 0
00000088 00000094 1 5 0000008C 0
00000094 00000098 1 6 000000A1 0
00000098 000000A0 1 7 0000009C 0
000000A0 000000A4 1 9 00000100 0
000000A4 000000A8 1 A 00000080 0
000000A8 000000AC 1 B 00000100 0
000000AC 000000B0 1 C 00000088 0
000000B0 000000B4 1 D 00000000 0
000000B4 000000B8 1 E 00000088 0
000000B8 000000BC 1 F 0000008B 0
000000BC 00000100 0 0 00000000 1
00000100 00000104 1 1 0000000B 0
00000104 00000108 1 3 000000BC 0
00000108 0000010C 1 3 000000C0 0
0000010C 00000110 0 0 00000000 0
00000110 000000C0 0 0 00000000 0
000000C0 00000100 0 0 00000000 1
00000100 00000104 1 1 00000002 0
00000104 00000108 1 3 000000C0 0
00000108 0000010C 1 3 000000C4 0
0000010C 00000110 0 0 00000000 0
00000110 000000C4 0 0 00000000 0
000000C4 000000C4 0 0 00000000 0
FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF

// ==== core_top.sv ====
`include "core_params.svh"

module core_top (
    input  logic               clk,
    input  logic               rst,
    output logic               imem_req_valid,
    input  logic               imem_req_ready,
    output logic [`XLEN-1:0]   imem_addr,
    input  logic               imem_resp_valid,
    input  logic [`XLEN-1:0]   imem_resp_data,
    output logic               retire_valid,
    output logic [`XLEN-1:0]   retire_pc,
    output logic [`XLEN-1:0]   retire_next_pc,
    output logic               retire_rd_wen,
    output logic [`REG_AW-1:0] retire_rd_addr,
    output logic [`XLEN-1:0]   retire_rd_data,
    output logic               retire_trap
);
    import core_pkg::*;

    // fetch to execute
    logic               inst_valid, inst_ready;
    logic [`XLEN-1:0]   inst, inst_pc;
    // register and csr read side
    logic [`REG_AW-1:0] rs1_addr, rs2_addr;
    logic [`XLEN-1:0]   rs1_data, rs2_data;
    logic [`CSR_AW-1:0] csr_raddr;
    logic [`XLEN-1:0]   csr_rdata, mtvec, mepc;
    // execute to writeback
    logic               ex_valid, ex_ready, ex_rd_wen, ex_trap, ex_mret;
    logic [`XLEN-1:0]   ex_pc, ex_next_pc, ex_rd_data, ex_csr_wdata, ex_cause;
    logic [`REG_AW-1:0] ex_rd_addr;
    logic [`CSR_AW-1:0] ex_csr_addr;
    csr_op_e            ex_csr_op;
    // commit side
    logic               rf_wen, csr_valid, trap, redirect_valid;
    logic [`REG_AW-1:0] rf_waddr;
    logic [`XLEN-1:0]   rf_wdata, csr_wdata, trap_pc, cause, redirect_pc;
    logic [`CSR_AW-1:0] csr_waddr;
    csr_op_e            csr_op;

    fetch_unit u_fetch (
        .clk (clk), .rst (rst),
        .imem_req_ready  (imem_req_ready),
        .imem_resp_valid (imem_resp_valid),
        .imem_resp_data  (imem_resp_data),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .inst_ready      (inst_ready),
        .imem_req_valid  (imem_req_valid),
        .imem_addr       (imem_addr),
        .inst_valid      (inst_valid),
        .inst            (inst),
        .inst_pc         (inst_pc)
    );

    execute_unit u_execute (
        .inst_valid (inst_valid), .inst (inst), .inst_pc (inst_pc),
        .inst_ready (inst_ready),
        .rs1_addr (rs1_addr), .rs2_addr (rs2_addr),
        .rs1_data (rs1_data), .rs2_data (rs2_data),
        .csr_raddr (csr_raddr), .csr_rdata (csr_rdata),
        .mtvec (mtvec), .mepc (mepc),
        .ex_ready (ex_ready), .ex_valid (ex_valid),
        .ex_pc (ex_pc), .ex_next_pc (ex_next_pc),
        .ex_rd_wen (ex_rd_wen), .ex_rd_addr (ex_rd_addr), .ex_rd_data (ex_rd_data),
        .ex_csr_op (ex_csr_op), .ex_csr_addr (ex_csr_addr),
        .ex_csr_wdata (ex_csr_wdata),
        .ex_trap (ex_trap), .ex_cause (ex_cause), .ex_mret (ex_mret)
    );

    writeback_unit u_writeback (
        .clk (clk), .rst (rst),
        .ex_valid (ex_valid), .ex_ready (ex_ready),
        .ex_pc (ex_pc), .ex_next_pc (ex_next_pc),
        .ex_rd_wen (ex_rd_wen), .ex_rd_addr (ex_rd_addr), .ex_rd_data (ex_rd_data),
        .ex_csr_op (ex_csr_op), .ex_csr_addr (ex_csr_addr),
        .ex_csr_wdata (ex_csr_wdata),
        .ex_trap (ex_trap), .ex_cause (ex_cause), .ex_mret (ex_mret),
        .rf_wen (rf_wen), .rf_waddr (rf_waddr), .rf_wdata (rf_wdata),
        .csr_valid (csr_valid), .csr_op (csr_op),
        .csr_waddr (csr_waddr), .csr_wdata (csr_wdata),
        .trap (trap), .trap_pc (trap_pc), .cause (cause),
        .redirect_valid (redirect_valid), .redirect_pc (redirect_pc),
        .retire_valid (retire_valid), .retire_pc (retire_pc),
        .retire_next_pc (retire_next_pc), .retire_rd_wen (retire_rd_wen),
        .retire_rd_addr (retire_rd_addr), .retire_rd_data (retire_rd_data),
        .retire_trap (retire_trap)
    );

    register_file u_regs (
        .clk (clk), .rst (rst),
        .wen (rf_wen), .waddr (rf_waddr), .wdata (rf_wdata),
        .raddr1 (rs1_addr), .raddr2 (rs2_addr),
        .rdata1 (rs1_data), .rdata2 (rs2_data)
    );

    csr_file u_csr (
        .clk (clk), .rst (rst),
        .raddr (csr_raddr), .rdata (csr_rdata),
        .csr_valid (csr_valid), .csr_op (csr_op),
        .waddr (csr_waddr), .wdata (csr_wdata),
        .trap (trap), .trap_pc (trap_pc), .cause (cause),
        .mtvec (mtvec), .mepc (mepc)
    );

endmodule

// ==== csr_file.sv ====
`include "core_params.svh"

module csr_file (
    input  logic               clk,
    input  logic               rst,
    input  logic [`CSR_AW-1:0] raddr,
    output logic [`XLEN-1:0]   rdata,
    input  logic               csr_valid,
    input  core_pkg::csr_op_e  csr_op,
    input  logic [`CSR_AW-1:0] waddr,
    input  logic [`XLEN-1:0]   wdata,
    input  logic               trap,
    input  logic [`XLEN-1:0]   trap_pc,
    input  logic [`XLEN-1:0]   cause,
    output logic [`XLEN-1:0]   mtvec,
    output logic [`XLEN-1:0]   mepc
);
    import core_pkg::*;

    logic [`XLEN-1:0] mstatus;
    logic [`XLEN-1:0] mcause;
    logic [`XLEN-1:0] wr_old;
    logic [`XLEN-1:0] wr_new;

    // unknown addresses read as zero, no trap
    function automatic logic [`XLEN-1:0] csr_read(input logic [`CSR_AW-1:0] addr);
        case (addr)
            `CSR_MSTATUS: csr_read = mstatus;
            `CSR_MTVEC:   csr_read = mtvec;
            `CSR_MEPC:    csr_read = mepc;
            `CSR_MCAUSE:  csr_read = mcause;
            default:      csr_read = '0;
        endcase
    endfunction

    assign rdata  = csr_read(raddr);
    assign wr_old = csr_read(waddr);
    // csrrs only sets bits
    assign wr_new = (csr_op == CSR_RS) ? (wr_old | wdata) : wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus <= '0;
            mtvec   <= `MTVEC_RESET;
            mepc    <= '0;
            mcause  <= '0;
        end else if (trap) begin
            mepc   <= trap_pc;
            mcause <= cause;
        end else if (csr_valid && csr_op != CSR_NONE) begin
            case (waddr)
                `CSR_MSTATUS: mstatus <= wr_new;
                `CSR_MTVEC:   mtvec   <= wr_new;
                `CSR_MEPC:    mepc    <= wr_new;
                `CSR_MCAUSE:  mcause  <= wr_new;
                default:      ;
            endcase
        end
    end

endmodule

// ==== decode_unit.sv ====
`include "core_params.svh"

module decode_unit (
    input  logic [`XLEN-1:0]   inst,
    output logic [`REG_AW-1:0] rs1_addr,
    output logic [`REG_AW-1:0] rs2_addr,
    output logic [`REG_AW-1:0] rd_addr,
    output logic [`XLEN-1:0]   imm,
    output core_pkg::alu_op_e  alu_op,
    output core_pkg::opa_sel_e opa_sel,
    output core_pkg::opb_sel_e opb_sel,
    output core_pkg::br_op_e   br_op,
    output core_pkg::pc_sel_e  pc_sel,
    output core_pkg::wb_sel_e  wb_sel,
    output logic               rd_wen,
    output core_pkg::csr_op_e  csr_op,
    output logic [`CSR_AW-1:0] csr_addr,
    output logic               illegal,
    output logic               ecall,
    output logic               mret
);
    import core_pkg::*;

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] imm_i, imm_b, imm_u, imm_j;
    logic             bad_enc;
    // which register fields the format really uses
    logic             use_rs1, use_rs2, use_rd;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign funct7   = inst[31:25];
    assign rs1_addr = inst[18:15];
    assign rs2_addr = inst[23:20];
    assign rd_addr  = inst[10:7];
    assign csr_addr = inst[31:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        imm     = imm_i;
        alu_op  = ALU_ADD;
        opa_sel = OPA_RS1;
        opb_sel = OPB_IMM;
        br_op   = BR_NONE;
        pc_sel  = PC_PLUS4;
        wb_sel  = WB_ALU;
        csr_op  = CSR_NONE;
        ecall   = 1'b0;
        mret    = 1'b0;
        bad_enc = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        use_rd  = 1'b0;
        case (opcode)
            // lui
            7'b0110111: begin
                imm     = imm_u;
                opa_sel = OPA_ZERO;
                alu_op  = ALU_PASS_B;
                use_rd  = 1'b1;
            end
            // auipc
            7'b0010111: begin
                imm     = imm_u;
                opa_sel = OPA_PC;
                use_rd  = 1'b1;
            end
            // jal
            7'b1101111: begin
                imm    = imm_j;
                pc_sel = PC_JAL;
                wb_sel = WB_PC4;
                use_rd = 1'b1;
            end
            // jalr
            7'b1100111: begin
                pc_sel  = PC_JALR;
                wb_sel  = WB_PC4;
                use_rs1 = 1'b1;
                use_rd  = 1'b1;
                bad_enc = (funct3 != 3'b000);
            end
            // branches
            7'b1100011: begin
                imm     = imm_b;
                pc_sel  = PC_BRANCH;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                case (funct3)
                    3'b000:  br_op = BR_EQ;
                    3'b001:  br_op = BR_NE;
                    3'b100:  br_op = BR_LT;
                    3'b101:  br_op = BR_GE;
                    3'b110:  br_op = BR_LTU;
                    3'b111:  br_op = BR_GEU;
                    default: bad_enc = 1'b1;
                endcase
            end
            // op-imm and op share the funct3 map
            7'b0010011, 7'b0110011: begin
                use_rs1 = 1'b1;
                use_rd  = 1'b1;
                if (opcode[5]) begin
                    opb_sel = OPB_RS2;
                    use_rs2 = 1'b1;
                end
                case (funct3)
                    3'b000:  alu_op = (opcode[5] && funct7[5]) ? ALU_SUB : ALU_ADD;
                    3'b001:  alu_op = ALU_SLL;
                    3'b010:  alu_op = ALU_SLT;
                    3'b011:  alu_op = ALU_SLTU;
                    3'b100:  alu_op = ALU_XOR;
                    3'b101:  alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                    3'b110:  alu_op = ALU_OR;
                    default: alu_op = ALU_AND;
                endcase
                // funct7 only means something for shifts and the register group
                if (opcode[5] || funct3 == 3'b001 || funct3 == 3'b101) begin
                    if (funct7 != 7'h00 && funct7 != 7'h20) bad_enc = 1'b1;
                    if (funct7 == 7'h20 && funct3 != 3'b101 && !(opcode[5] && funct3 == 3'b000))
                        bad_enc = 1'b1;
                end
            end
            // system
            7'b1110011: begin
                case (funct3)
                    3'b000: begin
                        if (inst == 32'h0000_0073) ecall = 1'b1;
                        else if (inst == 32'h3020_0073) begin
                            mret   = 1'b1;
                            pc_sel = PC_MRET;
                        end else bad_enc = 1'b1;
                    end
                    3'b001, 3'b010: begin
                        csr_op  = funct3[1] ? CSR_RS : CSR_RW;
                        wb_sel  = WB_CSR;
                        use_rs1 = 1'b1;
                        use_rd  = 1'b1;
                    end
                    default: bad_enc = 1'b1;
                endcase
            end
            default: bad_enc = 1'b1;
        endcase
        // x16..x31 do not exist in rv32e
        illegal = bad_enc | (use_rs1 & inst[19]) | (use_rs2 & inst[24]) | (use_rd & inst[11]);
        rd_wen  = use_rd;
        if (illegal || ecall) pc_sel = PC_TRAP;
    end

endmodule

// ==== execute_unit.sv ====
`include "core_params.svh"

module execute_unit (
    input  logic                inst_valid,
    input  logic [`XLEN-1:0]    inst,
    input  logic [`XLEN-1:0]    inst_pc,
    output logic                inst_ready,
    output logic [`REG_AW-1:0]  rs1_addr,
    output logic [`REG_AW-1:0]  rs2_addr,
    input  logic [`XLEN-1:0]    rs1_data,
    input  logic [`XLEN-1:0]    rs2_data,
    output logic [`CSR_AW-1:0]  csr_raddr,
    input  logic [`XLEN-1:0]    csr_rdata,
    input  logic [`XLEN-1:0]    mtvec,
    input  logic [`XLEN-1:0]    mepc,
    input  logic                ex_ready,
    output logic                ex_valid,
    output logic [`XLEN-1:0]    ex_pc,
    output logic [`XLEN-1:0]    ex_next_pc,
    output logic                ex_rd_wen,
    output logic [`REG_AW-1:0]  ex_rd_addr,
    output logic [`XLEN-1:0]    ex_rd_data,
    output core_pkg::csr_op_e   ex_csr_op,
    output logic [`CSR_AW-1:0]  ex_csr_addr,
    output logic [`XLEN-1:0]    ex_csr_wdata,
    output logic                ex_trap,
    output logic [`XLEN-1:0]    ex_cause,
    output logic                ex_mret
);
    import core_pkg::*;

    logic [`REG_AW-1:0] rd_addr;
    logic [`XLEN-1:0]   imm, opa, opb, alu_res, pc4;
    alu_op_e            alu_op;
    opa_sel_e           opa_sel;
    opb_sel_e           opb_sel;
    br_op_e             br_op;
    pc_sel_e            pc_sel;
    wb_sel_e            wb_sel;
    csr_op_e            csr_op;
    logic               rd_wen, illegal, ecall, mret, taken;

    decode_unit u_decode (
        .inst     (inst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd_addr  (rd_addr),
        .imm      (imm),
        .alu_op   (alu_op),
        .opa_sel  (opa_sel),
        .opb_sel  (opb_sel),
        .br_op    (br_op),
        .pc_sel   (pc_sel),
        .wb_sel   (wb_sel),
        .rd_wen   (rd_wen),
        .csr_op   (csr_op),
        .csr_addr (csr_raddr),
        .illegal  (illegal),
        .ecall    (ecall),
        .mret     (mret)
    );

    assign opa = (opa_sel == OPA_PC) ? inst_pc : (opa_sel == OPA_ZERO) ? '0 : rs1_data;
    assign opb = (opb_sel == OPB_IMM) ? imm : rs2_data;
    assign pc4 = inst_pc + 32'd4;

    always_comb begin
        case (alu_op)
            ALU_SUB:    alu_res = opa - opb;
            ALU_AND:    alu_res = opa & opb;
            ALU_OR:     alu_res = opa | opb;
            ALU_XOR:    alu_res = opa ^ opb;
            ALU_SLL:    alu_res = opa << opb[4:0];
            ALU_SRL:    alu_res = opa >> opb[4:0];
            ALU_SRA:    alu_res = $signed(opa) >>> opb[4:0];
            ALU_SLT:    alu_res = {31'b0, $signed(opa) < $signed(opb)};
            ALU_SLTU:   alu_res = {31'b0, opa < opb};
            ALU_PASS_B: alu_res = opb;
            default:    alu_res = opa + opb;
        endcase
    end

    // branch compares always use the two register operands
    always_comb begin
        case (br_op)
            BR_EQ:   taken = (rs1_data == rs2_data);
            BR_NE:   taken = (rs1_data != rs2_data);
            BR_LT:   taken = $signed(rs1_data) < $signed(rs2_data);
            BR_GE:   taken = $signed(rs1_data) >= $signed(rs2_data);
            BR_LTU:  taken = rs1_data < rs2_data;
            BR_GEU:  taken = rs1_data >= rs2_data;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (pc_sel)
            PC_BRANCH: ex_next_pc = taken ? inst_pc + imm : pc4;
            PC_JAL:    ex_next_pc = inst_pc + imm;
            // jalr target drops bit 0
            PC_JALR:   ex_next_pc = (rs1_data + imm) & ~32'd1;
            PC_TRAP:   ex_next_pc = mtvec;
            PC_MRET:   ex_next_pc = mepc;
            default:   ex_next_pc = pc4;
        endcase
    end

    assign ex_valid     = inst_valid;
    assign inst_ready   = ex_ready;
    assign ex_pc        = inst_pc;
    assign ex_trap      = illegal | ecall;
    assign ex_cause     = illegal ? `CAUSE_ILLEGAL : `CAUSE_ECALL;
    assign ex_mret      = mret & ~ex_trap;
    // trapping instructions and x0 leave the register file alone
    assign ex_rd_wen    = rd_wen & ~ex_trap & (rd_addr != '0);
    assign ex_rd_addr   = rd_addr;
    assign ex_rd_data   = (wb_sel == WB_PC4) ? pc4 : (wb_sel == WB_CSR) ? csr_rdata : alu_res;
    assign ex_csr_op    = ex_trap ? CSR_NONE : csr_op;
    assign ex_csr_addr  = csr_raddr;
    assign ex_csr_wdata = rs1_data;

endmodule

// ==== fetch_unit.sv ====
`include "core_params.svh"

module fetch_unit (
    input  logic             clk,
    input  logic             rst,
    input  logic             imem_req_ready,
    input  logic             imem_resp_valid,
    input  logic [`XLEN-1:0] imem_resp_data,
    input  logic             redirect_valid,
    input  logic [`XLEN-1:0] redirect_pc,
    input  logic             inst_ready,
    output logic             imem_req_valid,
    output logic [`XLEN-1:0] imem_addr,
    output logic             inst_valid,
    output logic [`XLEN-1:0] inst,
    output logic [`XLEN-1:0] inst_pc
);
    import core_pkg::*;

    fetch_state_e     state;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] inst_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FETCH_REQ;
            pc    <= `RESET_PC;
        end else begin
            case (state)
                // request held until memory takes it
                FETCH_REQ: if (imem_req_ready) state <= FETCH_WAIT;
                FETCH_WAIT: if (imem_resp_valid) state <= FETCH_HOLD;
                // offer the word until execute accepts
                FETCH_HOLD: if (inst_ready) state <= FETCH_STALL;
                // single instruction in flight until writeback redirects
                FETCH_STALL: begin
                    if (redirect_valid) begin
                        pc    <= redirect_pc;
                        state <= FETCH_REQ;
                    end
                end
                default: state <= FETCH_REQ;
            endcase
        end
    end

    // memory drops the word after its pulse so latch it here
    always_ff @(posedge clk) begin
        if (state == FETCH_WAIT && imem_resp_valid) inst_q <= imem_resp_data;
    end

    // no request while held in reset
    assign imem_req_valid = (state == FETCH_REQ) && !rst;
    assign imem_addr      = pc;
    assign inst_valid     = (state == FETCH_HOLD);
    assign inst           = inst_q;
    assign inst_pc        = pc;

endmodule

// ==== register_file.sv ====
`include "core_params.svh"

module register_file (
    input  logic              clk,
    input  logic              rst,
    input  logic              wen,
    input  logic [`REG_AW-1:0] waddr,
    input  logic [`REG_AW-1:0] raddr1,
    input  logic [`REG_AW-1:0] raddr2,
    input  logic [`XLEN-1:0]  wdata,
    output logic [`XLEN-1:0]  rdata1,
    output logic [`XLEN-1:0]  rdata2
);

    logic [`XLEN-1:0] regs [`REG_NUM];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_NUM; i++) regs[i] <= '0;
        end else if (wen && waddr != '0) begin
            // x0 never written so it stays zero
            regs[waddr] <= wdata;
        end
    end

    // asynchronous reads for the combinational execute stage
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary -j 0 --top-module tb_core -f src.f -o sim_core
status=0
./obj_dir/sim_core > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "^Test OK$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, exit status $status"
    exit 1
fi

// ==== src.f ====
+incdir+.
core_pkg.sv
fetch_unit.sv
decode_unit.sv
register_file.sv
csr_file.sv
execute_unit.sv
writeback_unit.sv
core_top.sv
tb_core.sv

// ==== tb_core.sv ====
`include "core_params.svh"

module tb_core;

    // program words at the bottom of the stim table and the trace from word 128
    localparam int STIM_WORDS = 1024;
    localparam int TRACE_BASE = 128;
    localparam int ROW_WORDS = 6;
    localparam logic [31:0] PROG_END = 32'h0000_0200;
    localparam int RETIRE_TIMEOUT = 200;

    logic               clk = 1'b0;
    logic               rst = 1'b1;
    logic               imem_req_valid;
    logic               imem_req_ready = 1'b0;
    logic [`XLEN-1:0]   imem_addr;
    logic               imem_resp_valid = 1'b0;
    logic [`XLEN-1:0]   imem_resp_data = '0;
    logic               retire_valid;
    logic [`XLEN-1:0]   retire_pc;
    logic [`XLEN-1:0]   retire_next_pc;
    logic               retire_rd_wen;
    logic [`REG_AW-1:0] retire_rd_addr;
    logic [`XLEN-1:0]   retire_rd_data;
    logic               retire_trap;

    logic [`XLEN-1:0] stim [STIM_WORDS];
    integer           seed = 32'hfd1e1e44;
    // memory model state
    logic             rst_q = 1'b1;
    logic             req_fire = 1'b0;
    logic [`XLEN-1:0] req_addr = '0;
    logic             resp_pending = 1'b0;
    int               resp_delay = 0;
    logic [31:0]      rnd;
    int               retired = 0;

    always #20 clk = ~clk;

    core_top UUT (
        .clk             (clk),
        .rst             (rst),
        .imem_req_valid  (imem_req_valid),
        .imem_req_ready  (imem_req_ready),
        .imem_addr       (imem_addr),
        .imem_resp_valid (imem_resp_valid),
        .imem_resp_data  (imem_resp_data),
        .retire_valid    (retire_valid),
        .retire_pc       (retire_pc),
        .retire_next_pc  (retire_next_pc),
        .retire_rd_wen   (retire_rd_wen),
        .retire_rd_addr  (retire_rd_addr),
        .retire_rd_data  (retire_rd_data),
        .retire_trap     (retire_trap)
    );

    // latch the accepted request address for the reply
    always @(posedge clk) begin
        // reset as the memory model sees it on the falling edge
        rst_q    <= rst;
        req_fire <= !rst && imem_req_valid && imem_req_ready;
        if (imem_req_valid && imem_req_ready) req_addr <= imem_addr;
    end

    // instruction memory with random ready and 0 to 5 cycles of reply delay
    always @(negedge clk) begin
        if (rst_q) begin
            imem_req_ready  = 1'b0;
            imem_resp_valid = 1'b0;
            resp_pending    = 1'b0;
        end else if (req_fire && req_addr >= PROG_END) begin
            $display("instruction fetch at %h falls outside the program area", req_addr);
            $display("Test FAILED");
            $fatal(1, "fetch out of range");
        end else begin
            imem_resp_valid = 1'b0;
            if (req_fire) begin
                rnd          = $random(seed);
                resp_delay   = rnd % 6;
                resp_pending = 1'b1;
            end
            if (resp_pending) begin
                if (resp_delay == 0) begin
                    // one pulse per accepted request
                    imem_resp_valid = 1'b1;
                    imem_resp_data  = stim[req_addr[11:2]];
                    resp_pending    = 1'b0;
                end else begin
                    resp_delay = resp_delay - 1;
                end
            end
            rnd            = $random(seed);
            imem_req_ready = rnd[0];
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s is %h, expected %h (retirement %0d)",
                     name, actual, expected, retired);
            $display("Test FAILED");
            $fatal(1, "retire mismatch");
        end
    endtask

    // wait for the next retire pulse and sample it on the falling edge
    task automatic wait_retire();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!retire_valid && cycles < RETIRE_TIMEOUT);
        if (!retire_valid) begin
            $display("no retirement arrived within %0d cycles after retirement %0d",
                     RETIRE_TIMEOUT, retired);
            $display("Test FAILED");
            $fatal(1, "retire timeout");
        end
    endtask

    initial begin
        int base;
        $readmemh("core_stim.txt", stim);
        repeat (16) begin
            @(negedge clk);
            // no fetch request while the core is held in reset
            check_value("imem_req_valid", {31'b0, imem_req_valid}, 32'd0);
        end
        rst = 1'b0;
        base = TRACE_BASE;
        // all ones in the pc column ends the trace
        while (stim[base] !== 32'hFFFF_FFFF && base <= STIM_WORDS - ROW_WORDS) begin
            wait_retire();
            check_value("retire_pc", retire_pc, stim[base]);
            check_value("retire_next_pc", retire_next_pc, stim[base+1]);
            check_value("retire_rd_wen", {31'b0, retire_rd_wen}, stim[base+2]);
            // rd fields only mean something when rd is written
            if (stim[base+2] == 32'd1) begin
                check_value("retire_rd_addr", {28'b0, retire_rd_addr}, stim[base+3]);
                check_value("retire_rd_data", retire_rd_data, stim[base+4]);
            end
            check_value("retire_trap", {31'b0, retire_trap}, stim[base+5]);
            retired++;
            base += ROW_WORDS;
        end
        $display("Test OK");
        $finish;
    end

endmodule

// ==== writeback_unit.sv ====
`include "core_params.svh"

module writeback_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               ex_valid,
    output logic               ex_ready,
    input  logic [`XLEN-1:0]   ex_pc,
    input  logic [`XLEN-1:0]   ex_next_pc,
    input  logic               ex_rd_wen,
    input  logic [`REG_AW-1:0] ex_rd_addr,
    input  logic [`XLEN-1:0]   ex_rd_data,
    input  core_pkg::csr_op_e  ex_csr_op,
    input  logic [`CSR_AW-1:0] ex_csr_addr,
    input  logic [`XLEN-1:0]   ex_csr_wdata,
    input  logic               ex_trap,
    input  logic [`XLEN-1:0]   ex_cause,
    input  logic               ex_mret,
    output logic               rf_wen,
    output logic [`REG_AW-1:0] rf_waddr,
    output logic [`XLEN-1:0]   rf_wdata,
    output logic               csr_valid,
    output core_pkg::csr_op_e  csr_op,
    output logic [`CSR_AW-1:0] csr_waddr,
    output logic [`XLEN-1:0]   csr_wdata,
    output logic               trap,
    output logic [`XLEN-1:0]   trap_pc,
    output logic [`XLEN-1:0]   cause,
    output logic               redirect_valid,
    output logic [`XLEN-1:0]   redirect_pc,
    output logic               retire_valid,
    output logic [`XLEN-1:0]   retire_pc,
    output logic [`XLEN-1:0]   retire_next_pc,
    output logic               retire_rd_wen,
    output logic [`REG_AW-1:0] retire_rd_addr,
    output logic [`XLEN-1:0]   retire_rd_data,
    output logic               retire_trap
);
    import core_pkg::*;

    logic accept;

    // never back-pressures execute
    assign ex_ready = 1'b1;
    assign accept   = ex_valid & ex_ready;

    // commit strobes land on the capture edge
    assign rf_wen    = accept & ex_rd_wen;
    assign rf_waddr  = ex_rd_addr;
    assign rf_wdata  = ex_rd_data;
    // mret and traps carry no csr write
    assign csr_valid = accept & ~ex_trap & ~ex_mret;
    assign csr_op    = ex_csr_op;
    assign csr_waddr = ex_csr_addr;
    assign csr_wdata = ex_csr_wdata;
    assign trap      = accept & ex_trap;
    assign trap_pc   = ex_pc;
    assign cause     = ex_cause;

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid   <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            retire_valid   <= accept;
            redirect_valid <= accept;
        end
    end

    // retire record behind the one-cycle pulse
    always_ff @(posedge clk) begin
        if (accept) begin
            retire_pc      <= ex_pc;
            retire_next_pc <= ex_next_pc;
            retire_rd_wen  <= ex_rd_wen;
            retire_rd_addr <= ex_rd_addr;
            retire_rd_data <= ex_rd_data;
            retire_trap    <= ex_trap;
        end
    end

    // fetch restarts where this instruction went
    assign redirect_pc = retire_next_pc;

endmodule
